// File: csb_testdata.txt
# op paddr(byte, hex) wdata(hex) expected_rdata(hex)
# op is W or R, the last column is ignored for writes
R 00000000 00000000 00100001
R 00000004 00000000 00000000
R 00000008 00000000 00000000
W 00000000 ffffffff 00000000
R 00000000 00000000 00100001
W 00000040 a5a5a5a5 00000000
W 00000044 0000beef 00000000
R 00000040 00000000 a5a5a5a5
R 00000044 00000000 0000beef
W 0000007c 11111111 00000000
W 0000007c 22222222 00000000
W 0000007c 33333333 00000000
W 0000007c 44444444 00000000
R 0000007c 00000000 44444444
W 00000020 deadbeef 00000000
R 00000020 00000000 00000000
W 00000080 cafef00d 00000000
R 00000080 00000000 00000000
R 00000040 00000000 a5a5a5a5
W 0000000c 00000005 00000000
R 00000004 00000000 00000005
W 00000008 00000002 00000000
R 00000008 00000000 00000002
W 00000008 00000004 00000000
R 00000004 00000000 00000005
R 0000000c 00000000 00000000
W 00000004 00000001 00000000
R 00000004 00000000 00000004
W 00000004 00000004 00000000
R 00000004 00000000 00000000

// File: src.f
dla_csb_pkg.sv
apb_csb_bridge.sv
csb_req_fifo.sv
csb_reg_block.sv
dla_csb_top.sv
tb_csb_checker.sv
tb_dla_csb.sv

// File: Makefile
TOP := tb_dla_csb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_dla_csb.sv
// runs from the project root so csb_testdata.txt is found, one apb transfer per data line, at most one in flight
`timescale 1ns/1ps

module tb_dla_csb;

   localparam int FIFO_DEPTH  = 4;
   localparam int NUM_SCRATCH = 16;

   typedef struct packed {
      logic [7:0]  op;                                   // ascii W or R
      logic [31:0] addr;
      logic [31:0] wdat;
      logic [31:0] rdat;                                 // expected read data
   } test_vec_t;

   logic        dla_csb_clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        dla_intr;
   logic [31:0] exp_rdata;
   int          errors;
   int          checked;
   int          cycles;
   int          limit;
   bit          load_ok;
   test_vec_t   tests [$];

   dla_csb_top #(
      .FIFO_DEPTH(FIFO_DEPTH),
      .NUM_SCRATCH(NUM_SCRATCH)
   ) u_dut (
      .dla_csb_clk(dla_csb_clk), .reset(reset),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .dla_intr(dla_intr)
   );

   tb_csb_checker #(
      .NUM_SCRATCH(NUM_SCRATCH)
   ) u_check (
      .dla_csb_clk(dla_csb_clk), .reset(reset),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .dla_intr(dla_intr),
      .exp_rdata(exp_rdata), .errors(errors), .checked(checked)
   );

   initial begin
      dla_csb_clk = 1'b0;
      forever #10 dla_csb_clk = ~dla_csb_clk;            // 20 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // test data and apb driver
   ////////////////////////////////////////////////////////////////////////////
   task automatic load_tests();
      int          fd;
      int          c;
      int          n;
      logic [7:0]  ch;
      logic [31:0] a;
      logic [31:0] w;
      logic [31:0] r;
      test_vec_t   tv;
      load_ok = 1'b1;
      fd = $fopen("csb_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open csb_testdata.txt");
         load_ok = 1'b0;
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         ch = 8'(c);
         if (ch == "#") begin
            while (c != -1 && 8'(c) != 8'h0a) c = $fgetc(fd); // skip comment line
         end else if (ch == "W" || ch == "R") begin
            n = $fscanf(fd, "%h %h %h", a, w, r);
            if (n != 3) begin
               $display("malformed line in test data after %0d tests", tests.size());
               load_ok = 1'b0;
            end
            tv = '{op: ch, addr: a, wdat: w, rdat: r};
            tests.push_back(tv);
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   // enters just after a rising edge, leaves just after the completing edge
   task automatic run_transfer(input test_vec_t tv);
      psel      = 1'b1;
      penable   = 1'b0;
      pwrite    = (tv.op == "W");
      paddr     = tv.addr;
      pwdata    = tv.wdat;
      exp_rdata = tv.rdat;
      @(posedge dla_csb_clk);
      #1 penable = 1'b1;                                 // access phase
      @(negedge dla_csb_clk);
      while (!pready) @(negedge dla_csb_clk);            // wait states
      @(posedge dla_csb_clk);
      #1 psel = 1'b0;
      penable = 1'b0;
   endtask

   always @(posedge dla_csb_clk) begin
      cycles++;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout, the tests did not finish within %0d cycles", limit);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      reset     = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      exp_rdata = '0;
      limit     = 0;
      load_tests();
      limit = tests.size() * 20 + 100;
      repeat (4) @(posedge dla_csb_clk);
      #1 reset = 1'b0;
      foreach (tests[i]) begin
         run_transfer(tests[i]);
      end
      $display("tests run %0d of %0d, failed %0d", checked, tests.size(), errors);
      if (load_ok && tests.size() > 0 && checked == tests.size() && errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: tb_csb_checker.sv
// samples apb on the falling edge, models the default register map and counts failed transfers
`timescale 1ns/1ps

module tb_csb_checker #(
   parameter int NUM_SCRATCH = 16
) (
   input  logic        dla_csb_clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] prdata,
   input  logic        pready,
   input  logic        pslverr,
   input  logic        dla_intr,
   input  logic [31:0] exp_rdata,                     // from the data file
   output int          errors,
   output int          checked
);
   import dla_csb_pkg::*;

   localparam int IDX_W = (NUM_SCRATCH > 1) ? $clog2(NUM_SCRATCH) : 1;

   logic [31:0] status;
   logic [31:0] mask;
   logic [31:0] scratch [NUM_SCRATCH];
   logic [15:0] waddr;
   logic [31:0] model_rd;
   logic        model_intr;
   logic        ok;

   ////////////////////////////////////////////////////////////////////////////
   // register map model
   ////////////////////////////////////////////////////////////////////////////
   function automatic bit in_scratch(logic [15:0] a);
      return int'(a) >= int'(REG_SCRATCH_BASE) &&
             int'(a) <  int'(REG_SCRATCH_BASE) + NUM_SCRATCH;
   endfunction

   function automatic logic [31:0] model_read(logic [15:0] a);
      if (a == REG_ID) return DLA_ID_VALUE;
      if (a == REG_INTR_STATUS) return status;
      if (a == REG_INTR_MASK) return mask;
      if (in_scratch(a)) return scratch[IDX_W'(a - REG_SCRATCH_BASE)];
      return '0;                                         // doorbell and holes
   endfunction

   task automatic model_write(logic [15:0] a, logic [31:0] d);
      if (a == REG_INTR_STATUS) status = status & ~d;
      else if (a == REG_INTR_MASK) mask = d;
      else if (a == REG_DOORBELL) status = status | d;
      else if (in_scratch(a)) scratch[IDX_W'(a - REG_SCRATCH_BASE)] = d;
   endtask

   // reads are ordered behind earlier writes, so the model is current when one completes
   always @(negedge dla_csb_clk) begin
      if (reset) begin
         status  = '0;
         mask    = '0;
         errors  = 0;
         checked = 0;
      end else if (psel && penable && pready) begin
         checked++;
         ok    = 1'b1;
         waddr = paddr[17:2];
         if (pslverr !== 1'b0) begin
            $display("Mismatch pslverr: got 0x%0h, expected 0x0", pslverr);
            ok = 1'b0;
         end
         if (pwrite) begin
            model_write(waddr, pwdata);
         end else begin
            model_rd   = model_read(waddr);
            model_intr = |(status & mask);
            if (prdata !== model_rd) begin
               $display("Mismatch prdata: got 0x%08h, model 0x%08h", prdata, model_rd);
               ok = 1'b0;
            end
            if (prdata !== exp_rdata) begin
               $display("Mismatch prdata: got 0x%08h, data file 0x%08h", prdata, exp_rdata);
               ok = 1'b0;
            end
            if (dla_intr !== model_intr) begin
               $display("Mismatch dla_intr: got 0x%0h, expected 0x%0h", dla_intr, model_intr);
               ok = 1'b0;
            end
         end
         if (!ok) errors++;
         $display("test %0d %s paddr 0x%08h %s", checked, pwrite ? "W" : "R", paddr,
                  ok ? "ok" : "failed");
      end
   end

endmodule

// File: dla_csb_top.sv
// apb host port to csb register space on a single clock, no data backbone and no error responses
`timescale 1ns/1ps

module dla_csb_top #(
   parameter int FIFO_DEPTH  = 4,                        // power of two
   parameter int NUM_SCRATCH = 16
) (
   input  logic        dla_csb_clk,
   input  logic        reset,
   // apb
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        dla_intr
);
   import dla_csb_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // csb connections
   ////////////////////////////////////////////////////////////////////////////
   logic      push_valid;
   logic      push_ready;
   csb_req_t  push_req;
   logic      pop_valid;
   logic      pop_ready;
   csb_req_t  pop_req;
   logic      resp_valid;
   csb_resp_t resp;

   apb_csb_bridge bridge_0 (
      .dla_csb_clk(dla_csb_clk)
      ,.reset(reset)
      ,.psel(psel)
      ,.penable(penable)
      ,.pwrite(pwrite)
      ,.paddr(paddr)
      ,.pwdata(pwdata)
      ,.prdata(prdata)
      ,.pready(pready)
      ,.pslverr(pslverr)
      ,.push_valid(push_valid)
      ,.push_req(push_req)
      ,.push_ready(push_ready)
      ,.resp_valid(resp_valid)
      ,.resp(resp)
   );

   csb_req_fifo #(
      .payload_t(csb_req_t)
      ,.DEPTH(FIFO_DEPTH)
   ) fifo_0 (
      .dla_csb_clk(dla_csb_clk)
      ,.reset(reset)
      ,.push_valid(push_valid)
      ,.push_data(push_req)
      ,.push_ready(push_ready)
      ,.pop_valid(pop_valid)
      ,.pop_data(pop_req)
      ,.pop_ready(pop_ready)
   );

   csb_reg_block #(
      .NUM_SCRATCH(NUM_SCRATCH)
   ) regs_0 (
      .dla_csb_clk(dla_csb_clk)
      ,.reset(reset)
      ,.req_valid(pop_valid)
      ,.req(pop_req)
      ,.req_ready(pop_ready)
      ,.resp_valid(resp_valid)
      ,.resp(resp)
      ,.dla_intr(dla_intr)
   );

endmodule

// File: csb_reg_block.sv
// config space stand-in, one request per cycle, unmapped words read zero and drop writes
`timescale 1ns/1ps

module csb_reg_block #(
   parameter int NUM_SCRATCH = 16
) (
   input  logic                   dla_csb_clk,
   input  logic                   reset,
   input  logic                   req_valid,
   input  dla_csb_pkg::csb_req_t  req,
   output logic                   req_ready,
   output logic                   resp_valid,
   output dla_csb_pkg::csb_resp_t resp,
   output logic                   dla_intr
);
   import dla_csb_pkg::*;

   localparam int SCR_IDX_W = (NUM_SCRATCH > 1) ? $clog2(NUM_SCRATCH) : 1;
   localparam logic [CSB_ADDR_W-1:0] SCR_COUNT = CSB_ADDR_W'(NUM_SCRATCH);

   logic [CSB_DATA_W-1:0] intr_status;
   logic [CSB_DATA_W-1:0] intr_mask;
   logic [CSB_DATA_W-1:0] scratch [NUM_SCRATCH];
   logic [CSB_DATA_W-1:0] rd_data;
   logic [CSB_ADDR_W-1:0] scr_offset;
   logic [SCR_IDX_W-1:0]  scr_idx;
   logic                  scr_hit;
   logic                  accept;
   logic                  wr_accept;
   logic                  rd_accept;

   assign req_ready = !resp_valid;                       // one bubble per read
   assign accept    = req_valid && req_ready;
   assign wr_accept = accept && req.write;
   assign rd_accept = accept && req.nposted;

   ////////////////////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////////////////////
   assign scr_offset = req.addr - REG_SCRATCH_BASE;      // wraps high below the base
   assign scr_hit    = (scr_offset < SCR_COUNT);
   assign scr_idx    = scr_offset[SCR_IDX_W-1:0];

   always_comb begin
      rd_data = '0;
      case (req.addr)
         REG_ID:          rd_data = DLA_ID_VALUE;
         REG_INTR_STATUS: rd_data = intr_status;
         REG_INTR_MASK:   rd_data = intr_mask;
         REG_DOORBELL:    rd_data = '0;                  // write only
         default: begin
            if (scr_hit) begin
               rd_data = scratch[scr_idx];
            end
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers and interrupt
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge dla_csb_clk) begin
      if (reset) begin
         intr_status <= '0;
         intr_mask   <= '0;
         resp_valid  <= 1'b0;
         dla_intr    <= 1'b0;
      end else begin
         resp_valid <= rd_accept;
         dla_intr   <= |(intr_status & intr_mask);       // lags status by a cycle
         if (wr_accept) begin
            case (req.addr)
               REG_INTR_STATUS: intr_status <= intr_status & ~req.wdat;
               REG_INTR_MASK:   intr_mask   <= req.wdat;
               REG_DOORBELL:    intr_status <= intr_status | req.wdat;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge dla_csb_clk) begin
      if (wr_accept && scr_hit) begin
         scratch[scr_idx] <= req.wdat;
      end
      if (rd_accept) begin
         resp.data <= rd_data;
      end
   end

   // each request is either a posted write or a non-posted read, never both or neither
   a_req_kind : assert property (
      @(posedge dla_csb_clk) disable iff (reset) req_valid |-> req.write != req.nposted
   ) else $error("csb request is neither a plain write nor a plain read");

endmodule

// File: csb_req_fifo.sv
// first-word-fall-through fifo, DEPTH must be a power of two and at least 2
`timescale 1ns/1ps

module csb_req_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 4
) (
   input  logic     dla_csb_clk,
   input  logic     reset,
   // write side
   input  logic     push_valid,
   input  payload_t push_data,
   output logic     push_ready,
   // read side
   output logic     pop_valid,
   output payload_t pop_data,
   input  logic     pop_ready
);

   localparam int             IDX_W      = $clog2(DEPTH);
   localparam logic [IDX_W:0] FULL_LEVEL = (IDX_W + 1)'(DEPTH);

   payload_t       mem [DEPTH];
   logic [IDX_W:0] wr_ptr;                               // extra msb tells full from empty
   logic [IDX_W:0] rd_ptr;
   logic [IDX_W:0] level;
   logic           do_push;
   logic           do_pop;

   assign level      = wr_ptr - rd_ptr;
   assign push_ready = (level != FULL_LEVEL);
   assign pop_valid  = (level != '0);
   assign pop_data   = mem[rd_ptr[IDX_W-1:0]];           // head visible without a pop
   assign do_push    = push_valid && push_ready;
   assign do_pop     = pop_valid && pop_ready;

   always_ff @(posedge dla_csb_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge dla_csb_clk) begin
      if (do_push) begin
         mem[wr_ptr[IDX_W-1:0]] <= push_data;
      end
   end

   // a producer stalled by a full fifo keeps offering the same entry
   a_push_held : assert property (
      @(posedge dla_csb_clk) disable iff (reset)
      push_valid && !push_ready |=> push_valid && $stable(push_data)
   ) else $error("push dropped or changed while fifo full");

endmodule

// File: apb_csb_bridge.sv
// one apb transfer at a time, writes finish on fifo accept and reads stall until the csb response comes back
`timescale 1ns/1ps

module apb_csb_bridge (
   input  logic                 dla_csb_clk,
   input  logic                 reset,
   // apb slave side
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [31:0]          paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   // csb request toward the fifo
   output logic                 push_valid,
   output dla_csb_pkg::csb_req_t push_req,
   input  logic                 push_ready,
   // csb read response
   input  logic                 resp_valid,
   input  dla_csb_pkg::csb_resp_t resp
);
   import dla_csb_pkg::*;

   bridge_state_e state;
   logic          setup;                                 // apb setup phase seen
   logic          rd_done;                               // read data now in prdata

   assign setup      = psel && !penable;
   assign push_valid = (state == WAIT_PUSH);
   assign pslverr    = 1'b0;                             // no error responses on csb

   // writes complete as soon as the fifo takes them, reads one cycle after the response
   assign pready = (push_valid && push_ready && push_req.write) || rd_done;

   ////////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge dla_csb_clk) begin
      if (reset) begin
         state   <= IDLE;
         rd_done <= 1'b0;
      end else begin
         rd_done <= 1'b0;
         case (state)
            IDLE: begin
               if (setup) begin
                  state <= WAIT_PUSH;
               end
            end
            WAIT_PUSH: begin
               if (push_ready) begin
                  state <= push_req.write ? IDLE : WAIT_RESP;
               end
            end
            WAIT_RESP: begin
               if (resp_valid) begin
                  state   <= IDLE;
                  rd_done <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // request built from the setup phase, held stable while pushing
   always_ff @(posedge dla_csb_clk) begin
      if (state == IDLE && setup) begin
         push_req.addr    <= paddr[17:2];                // byte to word address
         push_req.wdat    <= pwdata;
         push_req.write   <= pwrite;
         push_req.nposted <= !pwrite;
      end
      if (resp_valid) begin
         prdata <= resp.data;
      end
   end

   // a response without an outstanding read means the register block and bridge disagree
   a_resp_only_when_waiting : assert property (
      @(posedge dla_csb_clk) disable iff (reset) resp_valid |-> state == WAIT_RESP
   ) else $error("csb response outside WAIT_RESP");

endmodule

// File: dla_csb_pkg.sv
// csb types and register map shared by all blocks, addresses are 16-bit word indices and byte strobes are not modelled
package dla_csb_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int CSB_ADDR_W = 16;                       // word address, apb bits 17:2
   localparam int CSB_DATA_W = 32;

   ////////////////////////////////////////////////////////////////////////////
   // request and response payloads
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [CSB_ADDR_W-1:0] addr;
      logic [CSB_DATA_W-1:0] wdat;
      logic                  write;
      logic                  nposted;                    // set for reads only
   } csb_req_t;

   typedef struct packed {
      logic [CSB_DATA_W-1:0] data;
   } csb_resp_t;

   ////////////////////////////////////////////////////////////////////////////
   // register map in word addresses
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [CSB_ADDR_W-1:0] REG_ID           = 16'h0000; // read only
   localparam logic [CSB_ADDR_W-1:0] REG_INTR_STATUS  = 16'h0001; // write 1 to clear
   localparam logic [CSB_ADDR_W-1:0] REG_INTR_MASK    = 16'h0002;
   localparam logic [CSB_ADDR_W-1:0] REG_DOORBELL     = 16'h0003; // sets status bits
   localparam logic [CSB_ADDR_W-1:0] REG_SCRATCH_BASE = 16'h0010;

   localparam logic [CSB_DATA_W-1:0] DLA_ID_VALUE = 32'h0010_0001;

   ////////////////////////////////////////////////////////////////////////////
   // bridge sequencing
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      IDLE,                                              // waiting for apb setup
      WAIT_PUSH,                                         // request offered to fifo
      WAIT_RESP                                          // read in flight
   } bridge_state_e;

endpackage
